// ==== flist.f ====
logic/tetris_pkg.sv
logic/key_strobe.sv
logic/piece_shape.sv
logic/piece_motion.sv
logic/board_check.sv
logic/game_fsm.sv
logic/line_clear.sv
logic/tetris_top.sv
testbench/tb_tetris.sv

// ==== logic/board_check.sv ====
`timescale 1ns/1ps

module board_check #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  tetris_pkg::piece_state_t  piece_i,
    input  tetris_pkg::piece_code_t   next_code_i,
    input  logic [ROWS-1:0][COLS-1:0] stored_i,
    output logic [ROWS-1:0][COLS-1:0] overlay_o,
    output tetris_pkg::collide_t      collide_o
);

    tetris_pkg::pattern_t cur_pat;
    tetris_pkg::pattern_t nxt_pat;

    piece_shape cur_shape_inst (.code_i(piece_i.code), .pattern_o(cur_pat));
    piece_shape nxt_shape_inst (.code_i(next_code_i), .pattern_o(nxt_pat));

    always_comb begin
        int ar;
        int ac;
        overlay_o = '0;
        collide_o = '{bottom: 1'b0, left: 1'b0, right: 1'b0, rot_ok: 1'b1};
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                ar = int'(piece_i.row) + r;
                ac = int'(piece_i.col) + c;
                if (cur_pat[r][c]) begin
                    // Cells outside the board are not drawn
                    if (ar < ROWS && ac < COLS) begin
                        overlay_o[ar][ac] = 1'b1;
                    end
                    if (ar + 1 >= ROWS) begin
                        collide_o.bottom = 1'b1;
                    end else if (ac < COLS && stored_i[ar+1][ac]) begin
                        collide_o.bottom = 1'b1;
                    end
                    // Grid already at column 0 has no position further left
                    if (ac == 0 || piece_i.col == 4'd0) begin
                        collide_o.left = 1'b1;
                    end else if (ar < ROWS && ac <= COLS && stored_i[ar][ac-1]) begin
                        collide_o.left = 1'b1;
                    end
                    if (ac + 1 >= COLS) begin
                        collide_o.right = 1'b1;
                    end else if (ar < ROWS && stored_i[ar][ac+1]) begin
                        collide_o.right = 1'b1;
                    end
                end
                // Rotated shape has to fit on free cells
                if (nxt_pat[r][c]) begin
                    if (ar >= ROWS || ac >= COLS) begin
                        collide_o.rot_ok = 1'b0;
                    end else if (stored_i[ar][ac]) begin
                        collide_o.rot_ok = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_i,
    input  tetris_pkg::move_cmd_t     cmd_i,
    input  logic                      drop_tick_i,
    input  tetris_pkg::collide_t      collide_i,
    input  tetris_pkg::piece_code_t   code_i,
    input  logic [ROWS-1:0][COLS-1:0] overlay_i,
    input  logic [ROWS-1:0][COLS-1:0] lc_board_i,
    input  logic                      lc_done_i,
    output tetris_pkg::game_state_t   state_o,
    output logic [ROWS-1:0][COLS-1:0] stored_o,
    output logic                      lc_start_o,
    output logic [ROWS-1:0][COLS-1:0] display_o,
    output logic                      gameover_o
);

    tetris_pkg::game_state_t next_state;
    logic                    armed_q;
    logic                    rot_req;

    // ========================================================================
    // State register and landing delay
    // ========================================================================
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state_o <= tetris_pkg::INIT;
            armed_q <= 1'b0;
        end else begin
            state_o <= next_state;
            // First collided cycle arms, a free cycle disarms
            if (state_o == tetris_pkg::FALLING) begin
                armed_q <= collide_i.bottom;
            end else if (state_o == tetris_pkg::SPAWN) begin
                armed_q <= 1'b0;
            end
        end
    end

    assign rot_req = (cmd_i.rot_cw || cmd_i.rot_ccw) && (code_i != tetris_pkg::CODE_O);

    always_comb begin
        next_state = state_o;
        case (state_o)
            tetris_pkg::INIT:    if (start_i) next_state = tetris_pkg::SPAWN;
            tetris_pkg::SPAWN:   next_state = tetris_pkg::FALLING;
            tetris_pkg::FALLING: begin
                if (collide_i.bottom && armed_q && drop_tick_i) begin
                    next_state = tetris_pkg::STUCK;
                end else if (rot_req) begin
                    next_state = tetris_pkg::ROTATE;
                end
            end
            tetris_pkg::ROTATE:  next_state = tetris_pkg::FALLING;
            tetris_pkg::STUCK:   begin
                // Blocks already in the top row end the game
                next_state = (|stored_o[0]) ? tetris_pkg::GAMEOVER : tetris_pkg::LANDED;
            end
            tetris_pkg::LANDED:  next_state = tetris_pkg::EVAL;
            tetris_pkg::EVAL:    if (lc_done_i) next_state = tetris_pkg::SPAWN;
            default:             next_state = state_o;
        endcase
    end

    // ========================================================================
    // Stored board and outputs
    // ========================================================================
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored_o <= '0;
        end else if (state_o == tetris_pkg::STUCK) begin
            stored_o <= stored_o | overlay_i;
        end else if (state_o == tetris_pkg::EVAL && lc_done_i) begin
            stored_o <= lc_board_i;
        end
    end

    assign lc_start_o = (state_o == tetris_pkg::LANDED);
    assign gameover_o = (state_o == tetris_pkg::GAMEOVER);

    always_comb begin
        case (state_o)
            tetris_pkg::SPAWN, tetris_pkg::FALLING,
            tetris_pkg::ROTATE, tetris_pkg::STUCK: display_o = stored_o | overlay_i;
            tetris_pkg::EVAL:                      display_o = lc_board_i;
            default:                               display_o = stored_o;
        endcase
    end

endmodule

// ==== logic/key_strobe.sv ====
`timescale 1ns/1ps

module key_strobe #(
    parameter bit FALL_EDGE = 1'b0
) (
    input  logic clk,
    input  logic reset,
    input  logic level_i,
    output logic pulse_o
);

    // Two synchronizer stages, then one stage of history for the edge
    logic [2:0] sync_q;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], level_i};
        end
    end

    assign pulse_o = FALL_EDGE ? (sync_q[2] & ~sync_q[1])
                               : (sync_q[1] & ~sync_q[2]);

endmodule

// ==== logic/line_clear.sv ====
`timescale 1ns/1ps

module line_clear #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_i,
    input  logic [ROWS-1:0][COLS-1:0] board_i,
    output logic [ROWS-1:0][COLS-1:0] board_o,
    output logic                      done_o,
    output logic [7:0]                score_o
);

    localparam int RW = $clog2(ROWS);

    logic [ROWS-1:0][COLS-1:0] src_q;
    logic [ROWS-1:0][COLS-1:0] work_q;
    logic [RW-1:0]             rd_q;
    logic [RW-1:0]             wr_q;
    logic [RW-1:0]             cleared_q;
    logic                      busy_q;
    logic                      row_full;

    assign row_full = &src_q[rd_q];

    // Control and score
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            busy_q    <= 1'b0;
            done_o    <= 1'b0;
            rd_q      <= '0;
            wr_q      <= '0;
            cleared_q <= '0;
            score_o   <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q    <= 1'b1;
                rd_q      <= RW'(ROWS - 1);
                wr_q      <= RW'(ROWS - 1);
                cleared_q <= '0;
            end else if (busy_q) begin
                rd_q <= rd_q - 1'b1;
                if (row_full) begin
                    cleared_q <= cleared_q + 1'b1;
                end else begin
                    wr_q <= wr_q - 1'b1;
                end
                // Top row done, score moves with the result
                if (rd_q == '0) begin
                    busy_q  <= 1'b0;
                    done_o  <= 1'b1;
                    score_o <= score_o + 8'(cleared_q) + 8'(row_full);
                end
            end
        end
    end

    // Rows above the last write position stay zero
    always_ff @(posedge clk) begin
        if (start_i) begin
            src_q  <= board_i;
            work_q <= '0;
        end else if (busy_q && !row_full) begin
            work_q[wr_q] <= src_q[rd_q];
        end
    end

    // Old board is shown until the compacted one is complete
    assign board_o = done_o ? work_q : src_q;

endmodule

// ==== logic/piece_motion.sv ====
`timescale 1ns/1ps

module piece_motion (
    input  logic                     clk,
    input  logic                     reset,
    input  tetris_pkg::game_state_t  state_i,
    input  tetris_pkg::move_cmd_t    cmd_i,
    input  logic                     drop_tick_i,
    input  tetris_pkg::collide_t     collide_i,
    output tetris_pkg::piece_state_t piece_o,
    output tetris_pkg::piece_code_t  next_code_o
);

    logic [2:0] spawn_cnt_q;
    logic       ccw_q;
    logic       ccw_sel;
    logic       stage;

    // Free-running base piece counter
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            spawn_cnt_q <= '0;
        end else if (spawn_cnt_q == 3'(tetris_pkg::NUM_BASE - 1)) begin
            spawn_cnt_q <= '0;
        end else begin
            spawn_cnt_q <= spawn_cnt_q + 3'd1;
        end
    end

    // Next piece is staged while the board is idle, so SPAWN already shows it
    assign stage = (state_i == tetris_pkg::INIT) || (state_i == tetris_pkg::LANDED) ||
                   (state_i == tetris_pkg::EVAL);

    // ========================================================================
    // Position and code registers
    // ========================================================================
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            piece_o <= '{code: '0, col: 4'(tetris_pkg::SPAWN_X), row: '0};
            ccw_q   <= 1'b0;
        end else if (stage) begin
            piece_o <= '{code: {2'b00, spawn_cnt_q}, col: 4'(tetris_pkg::SPAWN_X), row: '0};
        end else if (state_i == tetris_pkg::FALLING) begin
            // Direction is kept for the ROTATE cycle, where strobes are gone
            if (cmd_i.rot_cw || cmd_i.rot_ccw) begin
                ccw_q <= cmd_i.rot_ccw;
            end
            if (drop_tick_i && !collide_i.bottom) begin
                piece_o.row <= piece_o.row + 5'd1;
            end else if (cmd_i.left && !collide_i.left) begin
                piece_o.col <= piece_o.col - 4'd1;
            end else if (cmd_i.right && !collide_i.right) begin
                piece_o.col <= piece_o.col + 4'd1;
            end
        end else if (state_i == tetris_pkg::ROTATE && collide_i.rot_ok) begin
            piece_o.code <= next_code_o;
        end
    end

    // ========================================================================
    // Rotation table
    // ========================================================================
    assign ccw_sel = (state_i == tetris_pkg::ROTATE) ? ccw_q : cmd_i.rot_ccw;

    always_comb begin
        case (piece_o.code)
            5'd0:  next_code_o = 5'd7;
            5'd7:  next_code_o = 5'd0;
            5'd2:  next_code_o = 5'd9;
            5'd9:  next_code_o = 5'd2;
            5'd3:  next_code_o = 5'd8;
            5'd8:  next_code_o = 5'd3;
            5'd5:  next_code_o = ccw_sel ? 5'd15 : 5'd13;
            5'd13: next_code_o = ccw_sel ? 5'd5  : 5'd14;
            5'd14: next_code_o = ccw_sel ? 5'd13 : 5'd15;
            5'd15: next_code_o = ccw_sel ? 5'd14 : 5'd5;
            5'd4:  next_code_o = ccw_sel ? 5'd12 : 5'd10;
            5'd10: next_code_o = ccw_sel ? 5'd4  : 5'd11;
            5'd11: next_code_o = ccw_sel ? 5'd10 : 5'd12;
            5'd12: next_code_o = ccw_sel ? 5'd11 : 5'd4;
            5'd6:  next_code_o = ccw_sel ? 5'd16 : 5'd18;
            5'd18: next_code_o = ccw_sel ? 5'd6  : 5'd17;
            5'd17: next_code_o = ccw_sel ? 5'd18 : 5'd16;
            5'd16: next_code_o = ccw_sel ? 5'd17 : 5'd6;
            default: next_code_o = piece_o.code;
        endcase
    end

endmodule

// ==== logic/piece_shape.sv ====
`timescale 1ns/1ps

module piece_shape (
    input  tetris_pkg::piece_code_t code_i,
    output tetris_pkg::pattern_t    pattern_o
);

    // Nibbles run row 3 down to row 0, bit 0 of each nibble is column 0
    always_comb begin
        case (code_i)
            // I piece
            5'd0:  pattern_o = 16'b0010_0010_0010_0010;
            5'd7:  pattern_o = 16'b0000_0000_1111_0000;
            // Square
            5'd1:  pattern_o = 16'b0000_0000_0110_0110;
            // S piece
            5'd2:  pattern_o = 16'b0000_0000_0011_0110;
            5'd9:  pattern_o = 16'b0000_0010_0011_0001;
            // Z piece
            5'd3:  pattern_o = 16'b0000_0000_0110_0011;
            5'd8:  pattern_o = 16'b0000_0001_0011_0010;
            // J piece, clockwise order 4, 10, 11, 12
            5'd4:  pattern_o = 16'b0000_0000_0111_0001;
            5'd10: pattern_o = 16'b0000_0010_0010_0110;
            5'd11: pattern_o = 16'b0000_0000_0100_0111;
            5'd12: pattern_o = 16'b0000_0011_0010_0010;
            // L piece, clockwise order 5, 13, 14, 15
            5'd5:  pattern_o = 16'b0000_0000_0111_0100;
            5'd13: pattern_o = 16'b0000_0110_0010_0010;
            5'd14: pattern_o = 16'b0000_0000_0001_0111;
            5'd15: pattern_o = 16'b0000_0010_0010_0011;
            // T piece, clockwise order 6, 18, 17, 16
            5'd6:  pattern_o = 16'b0000_0000_0111_0010;
            5'd18: pattern_o = 16'b0000_0010_0110_0010;
            5'd17: pattern_o = 16'b0000_0000_0010_0111;
            5'd16: pattern_o = 16'b0000_0010_0011_0010;
            default: pattern_o = '0;
        endcase
    end

endmodule

// ==== logic/tetris_pkg.sv ====
package tetris_pkg;

    // ========================================================================
    // Board geometry and spawn settings
    // ========================================================================
    localparam int ROWS     = 20;
    localparam int COLS     = 10;
    localparam int SPAWN_X  = 3;
    localparam int NUM_BASE = 7;

    // Row-major, row 0 at the top
    typedef logic [ROWS-1:0][COLS-1:0] board_t;

    // 4x4 cell grid, indexed [row][col]
    typedef logic [3:0][3:0] pattern_t;

    // Piece and orientation, 0 to 18
    typedef logic [4:0] piece_code_t;

    // Square piece never rotates
    localparam piece_code_t CODE_O = 5'd1;

    typedef struct packed {
        piece_code_t code;
        logic [3:0]  col;
        logic [4:0]  row;
    } piece_state_t;

    typedef struct packed {
        logic bottom;
        logic left;
        logic right;
        logic rot_ok;
    } collide_t;

    typedef struct packed {
        logic left;
        logic right;
        logic rot_cw;
        logic rot_ccw;
    } move_cmd_t;

    typedef enum logic [2:0] {
        INIT,
        SPAWN,
        FALLING,
        ROTATE,
        STUCK,
        LANDED,
        EVAL,
        GAMEOVER
    } game_state_t;

endpackage

// ==== logic/tetris_top.sv ====
`timescale 1ns/1ps

module tetris_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                drop_clk_i,
    input  logic                start_i,
    input  logic                left_i,
    input  logic                right_i,
    input  logic                rot_cw_i,
    input  logic                rot_ccw_i,
    output tetris_pkg::board_t  display_o,
    output logic                gameover_o,
    output logic [7:0]          score_o
);

    logic left_p;
    logic right_p;
    logic cw_p;
    logic ccw_p;
    logic drop_tick;

    tetris_pkg::move_cmd_t    cmd;
    tetris_pkg::piece_state_t piece;
    tetris_pkg::piece_code_t  next_code;
    tetris_pkg::collide_t     collide;
    tetris_pkg::game_state_t  state;
    tetris_pkg::board_t       overlay;
    tetris_pkg::board_t       stored;
    tetris_pkg::board_t       lc_board;
    logic                     lc_start;
    logic                     lc_done;

    // ========================================================================
    // Button and drop clock strobes
    // ========================================================================
    key_strobe #(.FALL_EDGE(1'b0)) left_strobe_inst (
        .clk(clk), .reset(reset), .level_i(left_i), .pulse_o(left_p)
    );
    key_strobe #(.FALL_EDGE(1'b0)) right_strobe_inst (
        .clk(clk), .reset(reset), .level_i(right_i), .pulse_o(right_p)
    );
    key_strobe #(.FALL_EDGE(1'b0)) cw_strobe_inst (
        .clk(clk), .reset(reset), .level_i(rot_cw_i), .pulse_o(cw_p)
    );
    key_strobe #(.FALL_EDGE(1'b0)) ccw_strobe_inst (
        .clk(clk), .reset(reset), .level_i(rot_ccw_i), .pulse_o(ccw_p)
    );
    // Drop tick on the falling edge of the slow clock
    key_strobe #(.FALL_EDGE(1'b1)) drop_strobe_inst (
        .clk(clk), .reset(reset), .level_i(drop_clk_i), .pulse_o(drop_tick)
    );

    assign cmd = '{left: left_p, right: right_p, rot_cw: cw_p, rot_ccw: ccw_p};

    // ========================================================================
    // Game core
    // ========================================================================
    piece_motion piece_motion_inst (
        .clk(clk), .reset(reset), .state_i(state), .cmd_i(cmd),
        .drop_tick_i(drop_tick), .collide_i(collide),
        .piece_o(piece), .next_code_o(next_code)
    );

    board_check #(.ROWS(tetris_pkg::ROWS), .COLS(tetris_pkg::COLS)) board_check_inst (
        .piece_i(piece), .next_code_i(next_code), .stored_i(stored),
        .overlay_o(overlay), .collide_o(collide)
    );

    game_fsm #(.ROWS(tetris_pkg::ROWS), .COLS(tetris_pkg::COLS)) game_fsm_inst (
        .clk(clk), .reset(reset), .start_i(start_i), .cmd_i(cmd),
        .drop_tick_i(drop_tick), .collide_i(collide), .code_i(piece.code),
        .overlay_i(overlay), .lc_board_i(lc_board), .lc_done_i(lc_done),
        .state_o(state), .stored_o(stored), .lc_start_o(lc_start),
        .display_o(display_o), .gameover_o(gameover_o)
    );

    line_clear #(.ROWS(tetris_pkg::ROWS), .COLS(tetris_pkg::COLS)) line_clear_inst (
        .clk(clk), .reset(reset), .start_i(lc_start), .board_i(stored),
        .board_o(lc_board), .done_o(lc_done), .score_o(score_o)
    );

endmodule

// ==== testbench/tb_tetris.sv ====
`timescale 1ns/1ps

module tb_tetris;

    localparam int HALF_PERIOD  = 50;
    localparam int DROP_HALF    = 8;
    localparam int IDLE_CYCLES  = 11;
    localparam int SPAWN_WAIT   = 6;
    localparam int STEER_CYCLES = 20000;
    localparam int PLAY_CYCLES  = 40000;
    localparam int WATCHDOG     = 400 * 200;
    localparam int FULL_LIMIT   = tetris_pkg::ROWS + 4;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               drop_clk_i = 1'b0;
    logic               start_i = 1'b0;
    logic               left_i = 1'b0;
    logic               right_i = 1'b0;
    logic               rot_cw_i = 1'b0;
    logic               rot_ccw_i = 1'b0;
    tetris_pkg::board_t display_o;
    logic               gameover_o;
    logic [7:0]         score_o;

    integer             seed;
    int                 cyc = 0;
    int                 drop_cnt = 0;
    int                 last_left_cyc = -100;
    int                 lefts_piece = 0;
    int                 prev_cells = 0;
    int                 full_run [tetris_pkg::ROWS] = '{default: 0};
    logic [7:0]         prev_score = 8'h00;
    bit                 started = 1'b0;
    bit                 primed = 1'b0;
    bit                 spawn_seen = 1'b0;
    bit                 burst_watch = 1'b0;
    bit                 col0_seen = 1'b0;
    bit                 go_seen = 1'b0;
    tetris_pkg::board_t go_board;

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Slow drop clock, one full period every 16 cycles
    always @(posedge clk) begin
        #5;
        if (drop_cnt == DROP_HALF - 1) begin
            drop_cnt = 0;
            drop_clk_i = ~drop_clk_i;
        end else begin
            drop_cnt = drop_cnt + 1;
        end
    end

    tetris_top tetris_top_inst (
        .clk(clk), .reset(reset), .drop_clk_i(drop_clk_i), .start_i(start_i),
        .left_i(left_i), .right_i(right_i), .rot_cw_i(rot_cw_i), .rot_ccw_i(rot_ccw_i),
        .display_o(display_o), .gameover_o(gameover_o), .score_o(score_o)
    );

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic int count_cells(input tetris_pkg::board_t b);
        int n;
        n = 0;
        for (int r = 0; r < tetris_pkg::ROWS; r++) begin
            for (int c = 0; c < tetris_pkg::COLS; c++) begin
                n += b[r][c];
            end
        end
        return n;
    endfunction

    // Cells that lie outside rows 0-3 and columns 3-6
    function automatic int cells_outside_spawn(input tetris_pkg::board_t b);
        int n;
        n = 0;
        for (int r = 0; r < tetris_pkg::ROWS; r++) begin
            for (int c = 0; c < tetris_pkg::COLS; c++) begin
                if (b[r][c] && (r > 3 || c < 3 || c > 6)) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic next_edge();
        @(posedge clk);
        #5;
    endtask

    // One press and release, four cycles in all
    task automatic tap_button(input int which);
        for (int level = 1; level >= 0; level--) begin
            case (which)
                0:       left_i = level[0];
                1:       right_i = level[0];
                2:       rot_cw_i = level[0];
                default: rot_ccw_i = level[0];
            endcase
            next_edge();
        end
        repeat (2) next_edge();
    endtask

    task automatic rotate_or_wait();
        int pick;
        pick = int'($unsigned($random(seed)) % 4);
        if (pick < 2) begin
            tap_button(2 + pick);
        end else begin
            repeat (4) next_edge();
        end
    endtask

    // ========================================================================
    // Checks on the DUT outputs, sampled mid-cycle
    // ========================================================================
    always @(negedge clk) begin : monitor
        int         cells;
        logic [7:0] delta;
        if (!reset) begin
            cells = count_cells(display_o);
            delta = score_o - prev_score;
            if (!started) begin
                assert (display_o == '0 && !gameover_o && score_o == 8'h00) else begin
                    abort_run($sformatf("[FAIL] before start display_o=%h gameover_o=%h score_o=%h",
                        display_o, gameover_o, score_o));
                end
            end
            if (primed) begin
                assert (delta <= 8'd4) else begin
                    abort_run($sformatf("[FAIL] score_o stepped from %h to %h", prev_score, score_o));
                end
                // Ten cells leave per point scored, otherwise cells only appear
                assert (delta == 0 ? cells >= prev_cells : prev_cells - cells == 10 * int'(delta))
                else begin
                    abort_run($sformatf("[FAIL] display_o cells %h -> %h while score_o %h -> %h",
                        prev_cells, cells, prev_score, score_o));
                end
                // New piece on the board, a left already in flight still counts
                if (cells > prev_cells) begin
                    spawn_seen = 1'b1;
                    lefts_piece = (cyc - last_left_cyc < 5) ? 1 : 0;
                end
            end
            for (int r = 0; r < tetris_pkg::ROWS; r++) begin
                if (burst_watch && display_o[r][0]) begin
                    col0_seen = 1'b1;
                end
                full_run[r] = (&display_o[r] && !gameover_o) ? full_run[r] + 1 : 0;
                assert (full_run[r] <= FULL_LIMIT) else begin
                    abort_run($sformatf("[FAIL] display_o row %0d full for %h cycles",
                        r, full_run[r]));
                end
            end
            if (go_seen) begin
                assert (gameover_o && display_o == go_board) else begin
                    abort_run($sformatf("[FAIL] after game over gameover_o=%h display_o=%h",
                        gameover_o, display_o));
                end
            end else if (gameover_o) begin
                go_seen = 1'b1;
                go_board = display_o;
            end
            prev_cells = cells;
            prev_score = score_o;
            primed = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        abort_run($sformatf("Watchdog expired after %0d cycles with the game still running",
            WATCHDOG));
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        int waited;
        int shift;
        int phase_end;
        seed = 32'hf1e8;
        repeat (4) @(posedge clk);
        #5 reset = 1'b0;
        // Start cycle picks a first base piece with a cell in its left column
        repeat (IDLE_CYCLES) next_edge();
        start_i = 1'b1;
        started = 1'b1;
        waited = 0;
        while (display_o == '0 && waited < SPAWN_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (count_cells(display_o) == 4 && cells_outside_spawn(display_o) == 0) else begin
            abort_run($sformatf("[FAIL] display_o after start %h, cell count %h",
                display_o, count_cells(display_o)));
        end
        next_edge();
        start_i = 1'b0;

        // Long left burst pins the first piece to the left wall
        burst_watch = 1'b1;
        repeat (8) tap_button(0);
        burst_watch = 1'b0;
        assert (col0_seen) else begin
            abort_run("Left burst did not bring any displayed cell into column 0");
        end
        lefts_piece = 3;
        spawn_seen = 1'b0;

        // One random shift per new piece, then random rotations
        phase_end = cyc + STEER_CYCLES;
        while (!gameover_o && cyc < phase_end) begin
            if (spawn_seen) begin
                spawn_seen = 1'b0;
                shift = int'($unsigned($random(seed)) % 10) - 3;
                for (int i = 0; i < shift; i++) begin
                    tap_button(1);
                end
                for (int i = 0; i < -shift; i++) begin
                    if (lefts_piece < 3) begin
                        last_left_cyc = cyc;
                        lefts_piece++;
                        tap_button(0);
                    end
                end
            end else begin
                rotate_or_wait();
            end
        end

        // No more steering, the stack has to reach the top
        phase_end = cyc + PLAY_CYCLES;
        while (!gameover_o && cyc < phase_end) begin
            rotate_or_wait();
        end
        assert (gameover_o) else begin
            abort_run("Game over never came with steering off");
        end
        repeat (50) next_edge();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
